// ==== Makefile ====
# Verilator build and run for the pipelined Baugh-Wooley multiplier

TOP      ?= tb_bw_multiplier
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert
FILELIST ?= src.f
OBJ_DIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it reports a pass"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables (override on the command line):"
	@echo "  TOP=$(TOP) SIM=$(SIM) FLAGS='$(FLAGS)'"
	@echo "  FILELIST=$(FILELIST) OBJ_DIR=$(OBJ_DIR)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/bw_multiplier.sv ====
module bw_multiplier (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_valid,
    input  logic signed [mul_pkg::OP_W-1:0]   x,
    input  logic signed [mul_pkg::OP_W-1:0]   y,
    output logic                              out_valid,
    output logic signed [mul_pkg::PROD_W-1:0] z
);
    import mul_pkg::*;

    operand_t  op_in;
    operand_t  op_q;
    logic      op_valid;

    pp_rows_t  pp_rows;

    cs_pair_t  lo_pair;
    cs_pair_t  hi_pair;
    tree_out_t trees_d;
    tree_out_t trees_q;
    logic      trees_valid;

    assign op_in.x = x;
    assign op_in.y = y;

    // Stage 1 holds the operand pair
    pipe_stage #(
        .payload_t(operand_t)
    ) op_stage_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (op_in),
        .out_valid(op_valid),
        .out_data (op_q)
    );

    pp_gen pp_gen_i (
        .op  (op_q),
        .rows(pp_rows)
    );

    // Both halves of the rows are compressed side by side
    csa_tree tree_lo (
        .clk   (clk),
        .rows  (pp_rows[HALF_ROWS-1:0]),
        .result(lo_pair)
    );

    csa_tree tree_hi (
        .clk   (clk),
        .rows  (pp_rows[ROWS-1:HALF_ROWS]),
        .result(hi_pair)
    );

    assign trees_d.lo = lo_pair;
    assign trees_d.hi = hi_pair;

    // Stage 2 holds the two sum and carry pairs
    pipe_stage #(
        .payload_t(tree_out_t)
    ) tree_stage_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (op_valid),
        .in_data  (trees_d),
        .out_valid(trees_valid),
        .out_data (trees_q)
    );

    product_adder product_adder_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (trees_valid),
        .trees    (trees_q),
        .out_valid(out_valid),
        .z        (z)
    );

endmodule

// ==== source/csa_tree.sv ====
module csa_tree (
    input  logic                                              clk,
    input  logic [mul_pkg::HALF_ROWS-1:0][mul_pkg::PROD_W-1:0] rows,
    output mul_pkg::cs_pair_t                                 result
);
    import mul_pkg::*;

    cs_pair_t l1_a;     // Rows 0 to 2
    cs_pair_t l1_b;     // Rows 3 to 5
    cs_pair_t l2_a;
    cs_pair_t l2_b;
    cs_pair_t l3;
    cs_pair_t l4;

    logic [PROD_W-1:0] row_total;

    // Level 1 takes eight rows to six. Rows 6 and 7 pass straight through
    assign l1_a = csa3(rows[0], rows[1], rows[2]);
    assign l1_b = csa3(rows[3], rows[4], rows[5]);

    // Level 2 takes six to four
    assign l2_a = csa3(l1_a.sum, l1_a.carry, l1_b.sum);
    assign l2_b = csa3(l1_b.carry, rows[6], rows[7]);

    // Level 3 takes four to three, leaving l2_b.carry for the last level
    assign l3 = csa3(l2_a.sum, l2_a.carry, l2_b.sum);

    // Level 4 takes three to two
    assign l4 = csa3(l3.sum, l3.carry, l2_b.carry);

    assign result = l4;

    // Reference total of the eight rows, compared against the compressed pair
    always_comb begin
        row_total = '0;
        for (int i = 0; i < HALF_ROWS; i++) begin
            row_total = row_total + rows[i];
        end
    end

    // Rows come from a register with no reset, so the check waits for known data
    a_tree_sum: assert property (
        @(posedge clk) !$isunknown(rows) |-> (result.sum + result.carry == row_total)
    ) else $error("csa_tree pair does not add up to the row total");

endmodule

// ==== source/mul_pkg.sv ====
package mul_pkg;

    localparam int OP_W      = 16;          // Operand width
    localparam int PROD_W    = 2 * OP_W;    // Product width, also the column count
    localparam int ROWS      = OP_W;        // One partial-product row per bit of x
    localparam int HALF_ROWS = ROWS / 2;    // Rows reduced by each tree

    // Baugh-Wooley constant: a one at column OP_W and a one at the top column.
    // It cancels the bias that the inverted sign bits add to the rows
    localparam logic [PROD_W-1:0] BW_CORRECTION = 32'h8001_0000;

    typedef struct packed {
        logic signed [OP_W-1:0] x;
        logic signed [OP_W-1:0] y;
    } operand_t;

    // Each row is already shifted to its column, so a plain sum of rows is the product
    typedef logic [ROWS-1:0][PROD_W-1:0] pp_rows_t;

    typedef struct packed {
        logic [PROD_W-1:0] sum;
        logic [PROD_W-1:0] carry;
    } cs_pair_t;

    typedef struct packed {
        cs_pair_t hi;   // Rows 8 to 15
        cs_pair_t lo;   // Rows 0 to 7
    } tree_out_t;

    // One row of 3:2 full adders across all columns. The carry moves up one column
    // and whatever leaves the top column is dropped, which keeps the total modulo 2^32
    function automatic cs_pair_t csa3(
        input logic [PROD_W-1:0] a,
        input logic [PROD_W-1:0] b,
        input logic [PROD_W-1:0] c
    );
        cs_pair_t r;
        r.sum   = a ^ b ^ c;
        r.carry = ((a & b) | (a & c) | (b & c)) << 1;
        return r;
    endfunction

endpackage

// ==== source/pipe_stage.sv ====
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Data only moves with a valid strobe, so idle cycles keep the last payload
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(out_valid)
    ) else $error("pipe_stage valid bit is unknown");

endmodule

// ==== source/pp_gen.sv ====
module pp_gen (
    input  mul_pkg::operand_t op,
    output mul_pkg::pp_rows_t rows
);
    import mul_pkg::*;

    // Row i is y weighted by bit i of x, placed so that its lowest bit lands at column i.
    // Bits carrying a negative weight are inverted, which turns each subtraction into an
    // addition plus a bias that BW_CORRECTION removes at the end
    always_comb begin
        logic [OP_W-1:0] pp;
        for (int i = 0; i < ROWS; i++) begin
            pp = op.y & {OP_W{op.x[i]}};
            if (i == ROWS - 1) begin
                // Sign row of x: only the sign-by-sign bit is positive
                pp[OP_W-2:0] = ~pp[OP_W-2:0];
            end else begin
                pp[OP_W-1] = ~pp[OP_W-1];   // y sign bit times a positive x bit
            end
            rows[i] = PROD_W'(pp) << i;
        end
    end

endmodule

// ==== source/product_adder.sv ====
module product_adder (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_valid,
    input  mul_pkg::tree_out_t                trees,
    output logic                              out_valid,
    output logic signed [mul_pkg::PROD_W-1:0] z
);
    import mul_pkg::*;

    cs_pair_t merge_a;
    cs_pair_t merge_b;
    logic [PROD_W-1:0] total;

    // A 4:2 level built from two chained full-adder rows folds both trees into one pair
    assign merge_a = csa3(trees.lo.sum, trees.lo.carry, trees.hi.sum);
    assign merge_b = csa3(merge_a.sum, merge_a.carry, trees.hi.carry);

    // Carry-propagate add; the correction only touches columns 16 and 31
    assign total = merge_b.sum + merge_b.carry + BW_CORRECTION;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            z         <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                z <= total;   // Two's-complement product, modulo 2^32
            end
        end
    end

    a_merge_total: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid |-> (merge_b.sum + merge_b.carry
                      == trees.lo.sum + trees.lo.carry + trees.hi.sum + trees.hi.carry)
    ) else $error("product_adder merged pair does not add up to the tree total");

endmodule

// ==== src.f ====
source/mul_pkg.sv
source/pipe_stage.sv
source/pp_gen.sv
source/csa_tree.sv
source/product_adder.sv
source/bw_multiplier.sv
tests/tb_bw_multiplier.sv

// ==== tests/tb_bw_multiplier.sv ====
module tb_bw_multiplier;
    timeunit 1ns;
    timeprecision 1ps;

    import mul_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int LATENCY      = 3;      // Edges from an accepted pair to its result
    localparam int N_CORNER     = 10;
    localparam int N_STREAM     = 200;
    localparam int N_GAPPED     = 200;
    localparam int DRAIN_CYCLES = 2 * LATENCY + 4;

    // Isolated corners and every drain take DRAIN_CYCLES, a gapped pair at most four cycles
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 + N_CORNER * DRAIN_CYCLES + N_CORNER
                                   + N_STREAM + N_GAPPED * 4 + 4 * DRAIN_CYCLES + 10;

    localparam int T_ISOLATED = 0;
    localparam int T_CORNER   = 1;
    localparam int T_STREAM   = 2;
    localparam int T_GAPPED   = 3;

    typedef struct packed {
        logic signed [OP_W-1:0]   x;
        logic signed [OP_W-1:0]   y;
        logic        [PROD_W-1:0] z;
    } vector_t;

    typedef struct packed {
        int                test;
        int                index;
        logic [PROD_W-1:0] expected;
        int                due;    // Cycle count at which out_valid must be high
    } sb_entry_t;

    // Operand pairs and their two's-complement products
    localparam vector_t CORNERS [N_CORNER] = '{
        {16'h0000, 16'h0000, 32'h0000_0000},
        {16'h0001, 16'hFFFF, 32'hFFFF_FFFF},
        {16'h8000, 16'h8000, 32'h4000_0000},
        {16'h8000, 16'h7FFF, 32'hC000_8000},
        {16'h7FFF, 16'h7FFF, 32'h3FFF_0001},
        {16'hFFFF, 16'hFFFF, 32'h0000_0001},
        {16'h7FFF, 16'h8000, 32'hC000_8000},
        {16'h8000, 16'hFFFF, 32'h0000_8000},
        {16'h0003, 16'hFFFB, 32'hFFFF_FFF1},
        {16'h3039, 16'hFFFE, 32'hFFFF_9F8E}
    };

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     in_valid;
    logic signed [OP_W-1:0]   x;
    logic signed [OP_W-1:0]   y;
    logic                     out_valid;
    logic signed [PROD_W-1:0] z;

    int                cur_test;
    int                cur_index;
    logic [PROD_W-1:0] cur_exp;
    int                cycle = 0;
    bit                seen_out = 1'b0;
    integer            seed;
    sb_entry_t         exp_q[$];

    bw_multiplier bw_multiplier_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .x        (x),
        .y        (y),
        .out_valid(out_valid),
        .z        (z)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic string test_name(input int test);
        case (test)
            T_ISOLATED: return "isolated corner";
            T_CORNER:   return "back-to-back corner";
            T_STREAM:   return "stream";
            T_GAPPED:   return "gapped";
            default:    return "reset";
        endcase
    endfunction

    function automatic logic [PROD_W-1:0] signed_product(
        input logic signed [OP_W-1:0] a,
        input logic signed [OP_W-1:0] b
    );
        logic signed [PROD_W-1:0] wide_a;
        logic signed [PROD_W-1:0] wide_b;
        wide_a = a;   // Sign extension to the product width
        wide_b = b;
        return wide_a * wide_b;
    endfunction

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%08h actual 0x%08h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic apply_pair(input int test, input int index, input logic [OP_W-1:0] a,
                              input logic [OP_W-1:0] b, input logic [PROD_W-1:0] expected);
        in_valid  <= 1'b1;
        x         <= a;
        y         <= b;
        cur_test  <= test;
        cur_index <= index;
        cur_exp   <= expected;
        @(posedge clk);
    endtask

    task automatic idle_cycle();
        in_valid <= 1'b0;
        @(posedge clk);
    endtask

    // Waits for every pair in flight, then idles long enough to expose a late extra pulse
    task automatic wait_drain();
        in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (LATENCY + 1) @(posedge clk);
    endtask

    // Scoreboard and latency monitor, sampled away from the rising edge
    always @(negedge clk) begin
        sb_entry_t entry;
        string     name;
        if (!rst_n) begin
            check_value("reset out_valid", 32'd0, 32'(out_valid));
            check_value("reset z", 32'd0, z);
        end else begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("out_valid pulsed at cycle %0d with no pair in flight", cycle);
                    stop_with_failure();
                end
                entry = exp_q.pop_front();
                name  = $sformatf("%s #%0d", test_name(entry.test), entry.index);
                check_value({name, " latency"}, entry.due, cycle);
                check_value(name, entry.expected, z);
                seen_out = 1'b1;
            end else begin
                if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
                    name = $sformatf("%s #%0d", test_name(exp_q[0].test), exp_q[0].index);
                    check_value({name, " out_valid"}, 32'd1, 32'(out_valid));
                end
                if (!seen_out) begin
                    check_value("idle z after reset", 32'd0, z);
                end
            end
            // The pair was driven at the edge that set this cycle count and its result
            // is out LATENCY edges after that one
            if (in_valid) begin
                entry.test     = cur_test;
                entry.index    = cur_index;
                entry.expected = cur_exp;
                entry.due      = cycle + LATENCY;
                exp_q.push_back(entry);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, results are still missing", WATCHDOG_CYCLES);
        stop_with_failure();
    end

    initial begin
        vector_t     v;
        logic [31:0] r;
        seed = 32'hacf88e75;
        rst_n     <= 1'b0;
        in_valid  <= 1'b0;
        x         <= '0;
        y         <= '0;
        cur_test  <= 0;
        cur_index <= 0;
        cur_exp   <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);   // Quiet cycles right after reset

        // One strobe at a time shows the bare latency
        for (int i = 0; i < N_CORNER; i++) begin
            v = CORNERS[i];
            apply_pair(T_ISOLATED, i, v.x, v.y, v.z);
            wait_drain();
        end

        for (int i = 0; i < N_CORNER; i++) begin
            v = CORNERS[i];
            apply_pair(T_CORNER, i, v.x, v.y, v.z);
        end
        wait_drain();

        for (int i = 0; i < N_STREAM; i++) begin
            r = $random(seed);
            apply_pair(T_STREAM, i, r[31:16], r[15:0], signed_product(r[31:16], r[15:0]));
        end
        wait_drain();

        for (int i = 0; i < N_GAPPED; i++) begin
            r = $random(seed);
            apply_pair(T_GAPPED, i, r[31:16], r[15:0], signed_product(r[31:16], r[15:0]));
            r = $random(seed);
            repeat (r[1:0]) idle_cycle();
        end
        wait_drain();

        $display("RESULT: PASS");
        $finish;
    end

endmodule
